// ==== dv/usb_ulpi_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_ulpi_tb
  import ulpi_pkg::*;
();

  localparam int RESET_CYCLES    = 16;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 4000;
  localparam int LINESTATE_WAIT  = 100;

  logic       clock = 1'b0;
  logic       reset;
  usb_beat_t  host_tx_i;
  logic       host_tx_valid_i;
  logic       host_tx_ready_o;
  usb_beat_t  host_rx_o;
  logic       host_rx_valid_o;
  logic       host_rx_ready_i;
  usb_beat_t  bus_out_o;
  logic       bus_out_valid_o;
  logic       bus_out_ready_i;
  usb_beat_t  bus_in_i;
  logic       bus_in_valid_i;
  logic       bus_in_ready_o;
  logic [1:0] bus_linestate_i;
  logic [1:0] linestate_o;
  logic       rx_overflow_o;

  int seed = 77;

  // Beats to send, beats expected and beats seen for each direction
  usb_beat_t host_pkt_q[$];
  usb_beat_t exp_out_q[$];
  usb_beat_t got_out_q[$];
  usb_beat_t bus_pkt_q[$];
  usb_beat_t exp_rx_q[$];
  usb_beat_t got_rx_q[$];

  always #50 clock = ~clock;

  usb_ulpi_top i_usb_ulpi_top (
    .clock           (clock),
    .reset           (reset),
    .host_tx_i       (host_tx_i),
    .host_tx_valid_i (host_tx_valid_i),
    .host_tx_ready_o (host_tx_ready_o),
    .host_rx_o       (host_rx_o),
    .host_rx_valid_o (host_rx_valid_o),
    .host_rx_ready_i (host_rx_ready_i),
    .bus_out_o       (bus_out_o),
    .bus_out_valid_o (bus_out_valid_o),
    .bus_out_ready_i (bus_out_ready_i),
    .bus_in_i        (bus_in_i),
    .bus_in_valid_i  (bus_in_valid_i),
    .bus_in_ready_o  (bus_in_ready_o),
    .bus_linestate_i (bus_linestate_i),
    .linestate_o     (linestate_o),
    .rx_overflow_o   (rx_overflow_o)
  );

  function automatic int next_random();
    return $random(seed);
  endfunction

  function automatic int random_len(input int min_len);
    return min_len + (next_random() & 7);
  endfunction

  task automatic compare_beat(input string test, input int idx, input usb_beat_t exp,
                              input usb_beat_t act);
    if (act !== exp) begin
      $display("FAIL %s beat %0d: expected data %h last %b, actual data %h last %b",
               test, idx, exp.data, exp.last, act.data, act.last);
      $display("Finished with errors");
      $fatal(1, "Stream beat mismatch");
    end
  endtask

  task automatic compare_linestate(input string test, input logic [1:0] exp,
                                   input logic [1:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected linestate %b, actual %b", test, exp, act);
      $display("Finished with errors");
      $fatal(1, "Line state mismatch");
    end
  endtask

  task automatic compare_flag(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected rx_overflow %b, actual %b", test, exp, act);
      $display("Finished with errors");
      $fatal(1, "Overflow flag mismatch");
    end
  endtask

  // First byte is a PID with its complement in the upper nibble
  task automatic add_host_packet(input int len);
    usb_beat_t  beat;
    int         rnd;
    logic [3:0] pid;
    for (int k = 0; k < len; k++) begin
      rnd = next_random();
      if (k == 0) begin
        pid       = rnd[3:0];
        beat.data = {~pid, pid};
      end else begin
        beat.data = rnd[7:0];
      end
      beat.last = (k == len - 1);
      host_pkt_q.push_back(beat);
      exp_out_q.push_back(beat);
    end
  endtask

  task automatic add_bus_packet(input int len);
    usb_beat_t beat;
    int        rnd;
    for (int k = 0; k < len; k++) begin
      rnd       = next_random();
      beat.data = rnd[7:0];
      beat.last = (k == len - 1);
      bus_pkt_q.push_back(beat);
      exp_rx_q.push_back(beat);
    end
  endtask

  task automatic send_host_beats();
    int i;
    i = 0;
    while (i < host_pkt_q.size()) begin
      @(negedge clock);
      host_tx_i       = host_pkt_q[i];
      host_tx_valid_i = 1'b1;
      #1;
      if (host_tx_ready_o) begin
        // One idle cycle between packets
        if (host_pkt_q[i].last) begin
          @(negedge clock);
          host_tx_valid_i = 1'b0;
        end
        i++;
      end
    end
    host_pkt_q.delete();
  endtask

  task automatic send_bus_beats();
    int i;
    i = 0;
    while (i < bus_pkt_q.size()) begin
      @(negedge clock);
      bus_in_i       = bus_pkt_q[i];
      bus_in_valid_i = 1'b1;
      #1;
      if (bus_in_ready_o) begin
        if (bus_pkt_q[i].last) begin
          @(negedge clock);
          bus_in_valid_i = 1'b0;
        end
        i++;
      end
    end
    bus_pkt_q.delete();
  endtask

  task automatic collect_bus_out(input int count, input bit random_ready);
    int rnd;
    while (got_out_q.size() < count) begin
      @(negedge clock);
      if (random_ready) begin
        rnd             = next_random();
        bus_out_ready_i = rnd[0];
      end else begin
        bus_out_ready_i = 1'b1;
      end
      #1;
      if (bus_out_valid_o && bus_out_ready_i) begin
        got_out_q.push_back(bus_out_o);
      end
    end
    @(negedge clock);
    bus_out_ready_i = 1'b1;
  endtask

  task automatic collect_host_rx(input int count);
    while (got_rx_q.size() < count) begin
      @(negedge clock);
      host_rx_ready_i = 1'b1;
      #1;
      if (host_rx_valid_o && host_rx_ready_i) begin
        got_rx_q.push_back(host_rx_o);
      end
    end
  endtask

  task automatic check_bus_out(input string test);
    for (int i = 0; i < exp_out_q.size(); i++) begin
      compare_beat(test, i, exp_out_q[i], got_out_q[i]);
    end
    exp_out_q.delete();
    got_out_q.delete();
  endtask

  task automatic check_host_rx(input string test);
    for (int i = 0; i < exp_rx_q.size(); i++) begin
      compare_beat(test, i, exp_rx_q[i], got_rx_q[i]);
    end
    exp_rx_q.delete();
    got_rx_q.delete();
  endtask

  task automatic test_host_to_bus();
    add_host_packet(random_len(3));
    fork
      send_host_beats();
      collect_bus_out(exp_out_q.size(), 1'b0);
    join
    check_bus_out("host_to_bus");
  endtask

  task automatic test_bus_to_host();
    add_bus_packet(random_len(3));
    fork
      send_bus_beats();
      collect_host_rx(exp_rx_q.size());
    join
    check_host_rx("bus_to_host");
    compare_flag("bus_to_host", 1'b0, rx_overflow_o);
  endtask

  // Walk through 1, 2, 3, 0 so that every step is a change
  task automatic test_line_state();
    logic [1:0] value;
    int         waited;
    for (int k = 0; k < 4; k++) begin
      value = k[1:0] + 2'b01;
      @(negedge clock);
      bus_linestate_i = value;
      waited          = 0;
      while ((linestate_o !== value) && (waited < LINESTATE_WAIT)) begin
        @(negedge clock);
        waited++;
      end
      compare_linestate("line_state", value, linestate_o);
    end
  endtask

  task automatic test_back_pressure();
    add_host_packet(12);
    fork
      send_host_beats();
      collect_bus_out(exp_out_q.size(), 1'b1);
    join
    check_bus_out("back_pressure_tx");
    // Host stalls the whole receive so the packet sits in the FIFO
    @(negedge clock);
    host_rx_ready_i = 1'b0;
    add_bus_packet(10);
    send_bus_beats();
    repeat (8) @(negedge clock);
    collect_host_rx(10);
    check_host_rx("back_pressure_rx");
    compare_flag("back_pressure_rx", 1'b0, rx_overflow_o);
  endtask

  task automatic test_crossing_traffic();
    for (int k = 0; k < 3; k++) begin
      add_host_packet(random_len(2));
      add_bus_packet(random_len(2));
    end
    fork
      send_host_beats();
      send_bus_beats();
      collect_bus_out(exp_out_q.size(), 1'b0);
      collect_host_rx(exp_rx_q.size());
    join
    check_bus_out("crossing_tx");
    check_host_rx("crossing_rx");
    compare_flag("crossing_rx", 1'b0, rx_overflow_o);
  endtask

  initial begin
    reset           = 1'b1;
    host_tx_i       = '0;
    host_tx_valid_i = 1'b0;
    host_rx_ready_i = 1'b1;
    bus_out_ready_i = 1'b1;
    bus_in_i        = '0;
    bus_in_valid_i  = 1'b0;
    bus_linestate_i = 2'b00;
    repeat (RESET_CYCLES) @(negedge clock);
    reset = 1'b0;

    test_host_to_bus();
    test_bus_to_host();
    test_line_state();
    test_back_pressure();
    test_crossing_traffic();

    $display("Finished with no errors");
    $finish;
  end

  // Each test gets the same cycle budget
  initial begin
    repeat (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) @(posedge clock);
    $display("Timeout: the tests did not finish within %0d cycles",
             RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST);
    $display("Finished with errors");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

// ==== rtl/ulpi_defines.svh ====
`ifndef ULPI_DEFINES_SVH
`define ULPI_DEFINES_SVH

`default_nettype none

// Width of the ULPI data bus and of every stream byte
`define ULPI_DATA_W 8

// Upper nibble of a transmit TX CMD, the PID goes in the lower nibble
`define ULPI_TXCMD_TRANSMIT 4'h4

// Bytes buffered between the ULPI receive side and the host
`define RX_FIFO_DEPTH 16

// Start value of the PHY stall generator, must not be zero
`define PHY_LFSR_SEED 16'hACE1

`default_nettype wire

`endif

// ==== rtl/ulpi_link_rx.sv ====
`timescale 1ns/1ps
`include "ulpi_defines.svh"
`default_nettype none

module ulpi_link_rx
  import ulpi_pkg::*;
(
  input  logic           clock,
  input  logic           reset,

  // ULPI bus from the PHY
  input  ulpi_from_phy_t ulpi_i,

  // Received packet stream to the host
  output usb_beat_t      rx_o,
  output logic           rx_valid_o,
  input  logic           rx_ready_i,

  output logic [1:0]     linestate_o,
  output logic           rx_overflow_o
);

  localparam int ADDR_W = $clog2(`RX_FIFO_DEPTH);

  link_rx_state_e          state_q;
  logic [`ULPI_DATA_W-1:0] hold_q;
  logic                    hold_vld_q;
  usb_beat_t               mem [`RX_FIFO_DEPTH];
  logic [ADDR_W:0]         wr_ptr_q;
  logic [ADDR_W:0]         rd_ptr_q;
  logic                    is_data;
  logic                    is_cmd;
  logic                    dir_fall;
  logic                    push;
  logic                    pop;
  logic                    wr_en;
  logic                    full;
  logic                    empty;
  usb_beat_t               push_beat;

  // Sort the bus cycles while the PHY owns the bus
  assign is_data  = (state_q == rx_cmd_or_data) && ulpi_i.dir && ulpi_i.nxt;
  assign is_cmd   = (state_q == rx_cmd_or_data) && ulpi_i.dir && !ulpi_i.nxt;
  assign dir_fall = (state_q == rx_cmd_or_data) && !ulpi_i.dir;

  // Held byte is last when dir drops right after it
  assign push           = hold_vld_q && (is_data || dir_fall);
  assign push_beat.data = hold_q;
  assign push_beat.last = dir_fall;

  assign full  = (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W]) &&
                 (wr_ptr_q[ADDR_W-1:0] == rd_ptr_q[ADDR_W-1:0]);
  assign empty = (wr_ptr_q == rd_ptr_q);
  assign pop   = rx_valid_o && rx_ready_i;
  assign wr_en = push && (!full || pop);

  assign rx_o       = mem[rd_ptr_q[ADDR_W-1:0]];
  assign rx_valid_o = !empty;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= rx_idle;
    end else begin
      case (state_q)
        // First cycle with dir high is the turnaround
        rx_idle: begin
          if (ulpi_i.dir) begin
            state_q <= rx_cmd_or_data;
          end
        end
        rx_cmd_or_data: begin
          if (!ulpi_i.dir) begin
            state_q <= rx_turn;
          end
        end
        // Bus back with the link
        rx_turn: begin
          state_q <= ulpi_i.dir ? rx_cmd_or_data : rx_idle;
        end
        default: begin
          state_q <= rx_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      hold_vld_q    <= 1'b0;
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      linestate_o   <= 2'b00;
      rx_overflow_o <= 1'b0;
    end else begin
      if (is_data) begin
        hold_vld_q <= 1'b1;
      end else if (dir_fall) begin
        hold_vld_q <= 1'b0;
      end
      if (is_cmd) begin
        linestate_o <= ulpi_i.data[1:0];
      end
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Sticky until reset
      if (push && !wr_en) begin
        rx_overflow_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (is_data) begin
      hold_q <= ulpi_i.data;
    end
    if (wr_en) begin
      mem[wr_ptr_q[ADDR_W-1:0]] <= push_beat;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ulpi_link_tx.sv ====
`timescale 1ns/1ps
`include "ulpi_defines.svh"
`default_nettype none

module ulpi_link_tx
  import ulpi_pkg::*;
(
  input  logic           clock,
  input  logic           reset,

  // Host packet stream, first byte carries the PID
  input  usb_beat_t      tx_i,
  input  logic           tx_valid_i,
  output logic           tx_ready_o,

  // ULPI bus
  input  ulpi_from_phy_t ulpi_i,
  output ulpi_to_phy_t   ulpi_o
);

  link_tx_state_e state_q;
  logic           accept;

  // A byte leaves only when the PHY owns nxt and the bus is ours
  assign accept = tx_ready_o && tx_valid_i;

  // Bus drive and host back-pressure follow the state directly
  always_comb begin
    ulpi_o     = '0;
    tx_ready_o = 1'b0;
    case (state_q)
      tx_cmd: begin
        // PHY may grab the bus at any time, then we keep quiet
        if (!ulpi_i.dir) begin
          ulpi_o.data = {`ULPI_TXCMD_TRANSMIT, tx_i.data[3:0]};
          tx_ready_o  = ulpi_i.nxt;
        end
      end
      tx_data: begin
        // Host keeps the beats of one packet back to back
        if (!ulpi_i.dir) begin
          ulpi_o.data = tx_i.data;
          tx_ready_o  = ulpi_i.nxt;
        end
      end
      tx_stop: begin
        ulpi_o.stp = 1'b1;
      end
      default: begin
        ulpi_o.data = '0;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= tx_idle;
    end else begin
      case (state_q)
        tx_idle: begin
          // Wait for the bus while the PHY is receiving
          if (tx_valid_i && !ulpi_i.dir) begin
            state_q <= tx_cmd;
          end
        end
        tx_cmd: begin
          // TX CMD taken also consumes the PID byte
          if (accept) begin
            state_q <= tx_i.last ? tx_stop : tx_data;
          end
        end
        tx_data: begin
          if (accept && tx_i.last) begin
            state_q <= tx_stop;
          end
        end
        tx_stop: begin
          state_q <= tx_idle;
        end
        default: begin
          state_q <= tx_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ulpi_phy_model.sv ====
`timescale 1ns/1ps
`include "ulpi_defines.svh"
`default_nettype none

module ulpi_phy_model
  import ulpi_pkg::*;
(
  input  logic           clock,
  input  logic           reset,

  // ULPI bus
  input  ulpi_to_phy_t   ulpi_i,
  output ulpi_from_phy_t ulpi_o,

  // Packets the link transmitted, as seen on the cable
  output usb_beat_t      bus_out_o,
  output logic           bus_out_valid_o,
  input  logic           bus_out_ready_i,

  // Packets arriving from the cable
  input  usb_beat_t      bus_in_i,
  input  logic           bus_in_valid_i,
  output logic           bus_in_ready_o,

  input  logic [1:0]     bus_linestate_i
);

  phy_state_e              state_q;
  logic                    dir_q;
  logic                    nxt_q;
  logic [`ULPI_DATA_W-1:0] data_q;
  logic                    ls_turn_q;
  logic [1:0]              ls_q;
  logic                    last_sent_q;
  logic [15:0]             lfsr_q;
  logic [`ULPI_DATA_W-1:0] hold_q;
  logic                    hold_vld_q;
  logic                    hold_done_q;
  usb_beat_t               out_q;
  logic                    out_vld_q;
  logic                    stall;
  logic                    rx_active;
  logic                    ls_changed;
  logic                    txcmd_seen;
  logic                    take;
  logic                    drain;
  logic                    push;
  logic                    out_free;
  logic [`ULPI_DATA_W-1:0] rx_cmd;

  assign ulpi_o.dir  = dir_q;
  assign ulpi_o.nxt  = nxt_q;
  assign ulpi_o.data = data_q;

  assign bus_out_o       = out_q;
  assign bus_out_valid_o = out_vld_q;

  // Roughly one cycle in four is a stall
  assign stall = (lfsr_q[3:2] == 2'b11);

  assign rx_active  = (state_q == phy_recv) || ((state_q == phy_turn) && !ls_turn_q);
  assign ls_changed = (bus_linestate_i != ls_q);
  assign txcmd_seen = !ulpi_i.stp && (ulpi_i.data[7:4] == `ULPI_TXCMD_TRANSMIT);

  // RX CMD: ID high, RxActive event, VBUS valid, then line state
  assign rx_cmd = {2'b01, rx_active ? 2'b01 : 2'b00, 2'b11, bus_linestate_i};

  // Byte leaves the source only in the cycle before it goes on the bus
  assign bus_in_ready_o = (state_q == phy_recv) && !last_sent_q && !stall && bus_in_valid_i;

  // Transmit side, one byte held until the next byte or stp tells its last flag
  assign take     = (state_q == phy_send) && nxt_q && !ulpi_i.stp;
  assign out_free = !out_vld_q || bus_out_ready_i;
  assign drain    = hold_vld_q && hold_done_q && out_free;
  assign push     = (take && hold_vld_q) || drain;

  always_ff @(posedge clock) begin
    if (reset) begin
      lfsr_q <= `PHY_LFSR_SEED;
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q     <= phy_idle;
      dir_q       <= 1'b0;
      nxt_q       <= 1'b0;
      data_q      <= '0;
      ls_turn_q   <= 1'b0;
      ls_q        <= 2'b00;
      last_sent_q <= 1'b0;
    end else begin
      case (state_q)
        phy_idle: begin
          nxt_q <= 1'b0;
          // Line state first, then cable traffic, then the link
          if (ls_changed) begin
            dir_q     <= 1'b1;
            ls_turn_q <= 1'b1;
            state_q   <= phy_turn;
          end else if (bus_in_valid_i) begin
            dir_q     <= 1'b1;
            ls_turn_q <= 1'b0;
            state_q   <= phy_turn;
          end else if (txcmd_seen && !hold_vld_q) begin
            nxt_q   <= 1'b1;
            state_q <= phy_send;
          end
        end
        phy_turn: begin
          // Opening RX CMD after the turnaround
          data_q      <= rx_cmd;
          ls_q        <= bus_linestate_i;
          last_sent_q <= 1'b0;
          state_q     <= ls_turn_q ? phy_linestate : phy_recv;
        end
        phy_recv: begin
          if (last_sent_q) begin
            dir_q   <= 1'b0;
            nxt_q   <= 1'b0;
            data_q  <= '0;
            state_q <= phy_turnback;
          end else if (bus_in_ready_o) begin
            nxt_q       <= 1'b1;
            data_q      <= bus_in_i.data;
            last_sent_q <= bus_in_i.last;
          end else begin
            // Stall or empty source, fill with an RX CMD
            nxt_q  <= 1'b0;
            data_q <= rx_cmd;
            ls_q   <= bus_linestate_i;
          end
        end
        phy_linestate: begin
          dir_q   <= 1'b0;
          data_q  <= '0;
          state_q <= phy_turnback;
        end
        phy_turnback: begin
          state_q <= phy_idle;
        end
        phy_send: begin
          // nxt never two cycles in a row, so the output slot is free on every take
          nxt_q <= !ulpi_i.stp && !stall && !nxt_q && out_free;
          if (ulpi_i.stp) begin
            state_q <= phy_idle;
          end
        end
        default: begin
          state_q <= phy_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      hold_vld_q  <= 1'b0;
      hold_done_q <= 1'b0;
      out_vld_q   <= 1'b0;
    end else begin
      if (take) begin
        hold_vld_q <= 1'b1;
      end else if ((state_q == phy_send) && ulpi_i.stp) begin
        hold_done_q <= hold_vld_q;
      end else if (drain) begin
        hold_vld_q  <= 1'b0;
        hold_done_q <= 1'b0;
      end
      if (push) begin
        out_vld_q <= 1'b1;
      end else if (bus_out_ready_i) begin
        out_vld_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      // First take is the TX CMD, rebuild the full PID byte from it
      hold_q <= hold_vld_q ? ulpi_i.data : {~ulpi_i.data[3:0], ulpi_i.data[3:0]};
    end
    if (push) begin
      out_q.data <= hold_q;
      out_q.last <= drain;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ulpi_pkg.sv ====
`include "ulpi_defines.svh"
`default_nettype none

package ulpi_pkg;

  // One byte of a USB packet stream
  typedef struct packed {
    logic [`ULPI_DATA_W-1:0] data;
    logic                    last;
  } usb_beat_t;

  // Bus signals driven by the PHY
  typedef struct packed {
    logic                    dir;
    logic                    nxt;
    logic [`ULPI_DATA_W-1:0] data;
  } ulpi_from_phy_t;

  // Bus signals driven by the link
  typedef struct packed {
    logic                    stp;
    logic [`ULPI_DATA_W-1:0] data;
  } ulpi_to_phy_t;

  typedef enum logic [1:0] {
    tx_idle,
    tx_cmd,
    tx_data,
    tx_stop
  } link_tx_state_e;

  typedef enum logic [2:0] {
    phy_idle,
    phy_turn,
    phy_recv,
    phy_send,
    phy_linestate,
    phy_turnback
  } phy_state_e;

  typedef enum logic [1:0] {
    rx_idle,
    rx_turn,
    rx_cmd_or_data
  } link_rx_state_e;

endpackage

`default_nettype wire

// ==== rtl/usb_ulpi_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_ulpi_top
  import ulpi_pkg::*;
(
  input  logic       clock,
  input  logic       reset,

  // Host side
  input  usb_beat_t  host_tx_i,
  input  logic       host_tx_valid_i,
  output logic       host_tx_ready_o,
  output usb_beat_t  host_rx_o,
  output logic       host_rx_valid_o,
  input  logic       host_rx_ready_i,

  // Cable side of the PHY
  output usb_beat_t  bus_out_o,
  output logic       bus_out_valid_o,
  input  logic       bus_out_ready_i,
  input  usb_beat_t  bus_in_i,
  input  logic       bus_in_valid_i,
  output logic       bus_in_ready_o,
  input  logic [1:0] bus_linestate_i,

  output logic [1:0] linestate_o,
  output logic       rx_overflow_o
);

  // ULPI bus, one struct per direction
  ulpi_from_phy_t ulpi_from_phy;
  ulpi_to_phy_t   ulpi_to_phy;

  ulpi_link_tx i_ulpi_link_tx (
    .clock      (clock),
    .reset      (reset),
    .tx_i       (host_tx_i),
    .tx_valid_i (host_tx_valid_i),
    .tx_ready_o (host_tx_ready_o),
    .ulpi_i     (ulpi_from_phy),
    .ulpi_o     (ulpi_to_phy)
  );

  ulpi_link_rx i_ulpi_link_rx (
    .clock         (clock),
    .reset         (reset),
    .ulpi_i        (ulpi_from_phy),
    .rx_o          (host_rx_o),
    .rx_valid_o    (host_rx_valid_o),
    .rx_ready_i    (host_rx_ready_i),
    .linestate_o   (linestate_o),
    .rx_overflow_o (rx_overflow_o)
  );

  ulpi_phy_model i_ulpi_phy_model (
    .clock           (clock),
    .reset           (reset),
    .ulpi_i          (ulpi_to_phy),
    .ulpi_o          (ulpi_from_phy),
    .bus_out_o       (bus_out_o),
    .bus_out_valid_o (bus_out_valid_o),
    .bus_out_ready_i (bus_out_ready_i),
    .bus_in_i        (bus_in_i),
    .bus_in_valid_i  (bus_in_valid_i),
    .bus_in_ready_o  (bus_in_ready_o),
    .bus_linestate_i (bus_linestate_i)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the ULPI testbench with Verilator, run it and search the log for the pass message

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module usb_ulpi_tb -f usb_ulpi_top.f -o usb_ulpi_sim \
  && ./obj_dir/usb_ulpi_sim > sim.log 2>&1 \
  || echo "Build or simulation returned an error"

cat sim.log 2>/dev/null

grep -q "Finished with no errors" sim.log 2>/dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== usb_ulpi_top.f ====
+incdir+rtl
rtl/ulpi_pkg.sv
rtl/ulpi_link_tx.sv
rtl/ulpi_link_rx.sv
rtl/ulpi_phy_model.sv
rtl/usb_ulpi_top.sv
dv/usb_ulpi_tb.sv
